//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f all.f --top-module periph_tb -o periph_sim
	./obj_dir/periph_sim | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- all.f
source/bus_pkg.sv
source/periph_pkg.sv
source/address_decoder.sv
source/cpu_ram.sv
source/dsp_mult.sv
source/io_ports.sv
source/bus_arbiter.sv
source/periph_top.sv
verification/periph_asserts.sv
verification/periph_tb.sv

//--- source/address_decoder.sv
////////////////////////////////////////
// address decoder
// host request to one-hot region selects
////////////////////////////////////////

`timescale 1ns/1ps

module address_decoder #(
    parameter bit REGISTERED_INPUTS = 1'b1
) (
    input logic vdp_clk,
    input logic vdp_reset,
    input bus_pkg::bus_req_t req,
    output bus_pkg::sel_t sel
);

    bus_pkg::region_t region;
    bus_pkg::sel_t sel_comb;

    assign region = req.addr[bus_pkg::ADDR_W-1:bus_pkg::REGION_LSB];

    always_comb begin
        sel_comb = '0;
        if (req.valid) begin
            sel_comb.write = |req.wstrb;
            case (region)
                bus_pkg::REGION_RAM: sel_comb.ram = 1'b1;
                bus_pkg::REGION_DSP: sel_comb.dsp = 1'b1;
                bus_pkg::REGION_STATUS: sel_comb.status = 1'b1;
                bus_pkg::REGION_PAD: sel_comb.pad = 1'b1;
                // anything else still gets acknowledged
                default: sel_comb.unmapped = 1'b1;
            endcase
        end
    end

    generate
        if (REGISTERED_INPUTS) begin : g_registered
            // extra stage for slow CPU clock timing
            always_ff @(posedge vdp_clk) begin
                if (vdp_reset) begin
                    sel <= '0;
                end else begin
                    sel <= sel_comb;
                end
            end
        end else begin : g_direct
            assign sel = sel_comb;
        end
    endgenerate

endmodule

//--- source/bus_arbiter.sv
////////////////////////////////////////
// bus arbiter
// write routing, read mux and the
// host ready pulse
////////////////////////////////////////

`timescale 1ns/1ps

module bus_arbiter #(
    parameter int RAM_WORDS = 1024
) (
    input logic vdp_clk,
    input logic vdp_reset,
    input bus_pkg::bus_req_t req,
    input bus_pkg::sel_t sel,
    input bus_pkg::data_t ram_read_data,
    input periph_pkg::product_t product,
    input periph_pkg::status_t status,
    input logic pad_bit,
    output logic [$clog2(RAM_WORDS)-1:0] ram_index,
    output logic ram_cs,
    output bus_pkg::wstrb_t ram_wstrb,
    output logic dsp_write,
    output logic status_write,
    output logic pad_write,
    output bus_pkg::data_t read_data,
    output logic ready
);

    localparam int INDEX_W = $clog2(RAM_WORDS);

    logic sel_any;
    logic slow;
    logic start;
    logic fast_ack;
    logic wait_q;
    logic done;

    assign sel_any = sel.ram | sel.dsp | sel.status | sel.pad | sel.unmapped;
    // these wait one more cycle for the synchronous read
    assign slow = sel.ram | (sel.dsp & ~sel.write);
    assign start = sel_any & ~done & ~wait_q;
    assign fast_ack = start & ~slow;

    assign ram_index = req.addr[INDEX_W+1:2];

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            ready <= 1'b0;
            wait_q <= 1'b0;
            done <= 1'b0;
            ram_cs <= 1'b0;
            dsp_write <= 1'b0;
            status_write <= 1'b0;
            pad_write <= 1'b0;
        end else begin
            ready <= fast_ack | wait_q;
            wait_q <= start & slow;
            ram_cs <= start & sel.ram;
            dsp_write <= start & sel.dsp & sel.write;
            status_write <= start & sel.status & sel.write;
            pad_write <= start & sel.pad & sel.write;
            // hold off a repeat until the host drops valid
            if (!req.valid) begin
                done <= 1'b0;
            end else if (fast_ack | wait_q) begin
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge vdp_clk) begin
        if (start) begin
            ram_wstrb <= req.wstrb;
        end
    end

    // writes and unmapped accesses return zero
    always_comb begin
        read_data = '0;
        if (!sel.write) begin
            if (sel.ram) begin
                read_data = ram_read_data;
            end else if (sel.dsp) begin
                read_data = bus_pkg::data_t'(product);
            end else if (sel.status) begin
                read_data = {30'b0, status};
            end else if (sel.pad) begin
                read_data = {31'b0, pad_bit};
            end
        end
    end

endmodule

//--- source/bus_pkg.sv
////////////////////////////////////////
// host bus package
// request and select types plus the
// region codes of the address map
////////////////////////////////////////

package bus_pkg;

    localparam int ADDR_W = 24;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // region code sits in the top nibble of the byte address
    localparam int REGION_LSB = 20;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    // all strobes low means a read
    typedef logic [STRB_W-1:0] wstrb_t;
    typedef logic [ADDR_W-REGION_LSB-1:0] region_t;

    localparam region_t REGION_RAM = 4'd0;
    localparam region_t REGION_DSP = 4'd1;
    localparam region_t REGION_STATUS = 4'd2;
    localparam region_t REGION_PAD = 4'd3;

    // one host request, held stable while valid is high
    typedef struct packed {
        addr_t addr;
        wstrb_t wstrb;
        data_t write_data;
        logic valid;
    } bus_req_t;

    // decoder output, at most one select high
    typedef struct packed {
        logic ram;
        logic dsp;
        logic status;
        logic pad;
        logic unmapped;
        logic write;
    } sel_t;

endpackage

//--- source/cpu_ram.sv
////////////////////////////////////////
// CPU work RAM
// single port, synchronous read,
// byte write strobes
////////////////////////////////////////

`timescale 1ns/1ps

module cpu_ram #(
    parameter int RAM_WORDS = 1024
) (
    input logic vdp_clk,
    input logic [$clog2(RAM_WORDS)-1:0] index,
    input logic cs,
    input bus_pkg::wstrb_t wstrb,
    input bus_pkg::data_t write_data,
    output bus_pkg::data_t read_data
);

    bus_pkg::data_t mem [RAM_WORDS];

    always_ff @(posedge vdp_clk) begin
        if (cs) begin
            for (int i = 0; i < bus_pkg::STRB_W; i++) begin
                if (wstrb[i]) begin
                    mem[index][i*8 +: 8] <= write_data[i*8 +: 8];
                end
            end
            // old word on a write cycle
            read_data <= mem[index];
        end
    end

endmodule

//--- source/dsp_mult.sv
////////////////////////////////////////
// memory-mapped signed multiplier
////////////////////////////////////////

`timescale 1ns/1ps

module dsp_mult (
    input logic vdp_clk,
    input logic write_en,
    input logic select_b,
    input periph_pkg::operand_t operand_in,
    output periph_pkg::product_t product
);

    periph_pkg::operand_t operand_a;
    periph_pkg::operand_t operand_b;

    always_ff @(posedge vdp_clk) begin
        // flat enables so these land in the DSP input registers
        if (write_en && !select_b) begin
            operand_a <= operand_in;
        end

        if (write_en && select_b) begin
            operand_b <= operand_in;
        end

        product <= operand_a * operand_b;
    end

endmodule

//--- source/io_ports.sv
////////////////////////////////////////
// status LEDs and gamepad port
// pad is a latch plus serial shifter
// fed from the board buttons
////////////////////////////////////////

`timescale 1ns/1ps

module io_ports (
    input logic vdp_clk,
    input logic vdp_reset,
    input logic status_write,
    input logic pad_write,
    input logic [1:0] write_bits,
    input periph_pkg::buttons_t buttons,
    output periph_pkg::status_t status,
    output logic pad_bit,
    output logic led_r,
    output logic led_b
);

    logic [1:0] pad_ctrl;
    logic pad_clk_r;
    periph_pkg::pad_state_t pad_state;

    assign led_r = status[0];
    assign led_b = status[1];
    assign pad_bit = pad_state[0];

    always_ff @(posedge vdp_clk) begin
        if (vdp_reset) begin
            status <= periph_pkg::STATUS_RESET;
            pad_ctrl <= 2'b00;
            pad_clk_r <= 1'b0;
        end else begin
            if (status_write) begin
                status <= write_bits;
            end
            if (pad_write) begin
                pad_ctrl <= write_bits;
            end
            pad_clk_r <= pad_ctrl[1];
        end
    end

    // shift wins over latch, zero fill from the top
    always_ff @(posedge vdp_clk) begin
        if (pad_ctrl[1] && !pad_clk_r) begin
            pad_state <= {1'b0, pad_state[15:1]};
        end else if (pad_ctrl[0]) begin
            pad_state <= {8'b0, buttons[0], buttons[2], 5'b0, buttons[1]};
        end
    end

endmodule

//--- source/periph_pkg.sv
////////////////////////////////////////
// peripheral package
// data types of the math unit, status
// register and gamepad port
////////////////////////////////////////

package periph_pkg;

    localparam int OPERAND_W = 16;

    typedef logic signed [OPERAND_W-1:0] operand_t;
    typedef logic signed [2*OPERAND_W-1:0] product_t;

    // bit 0 red LED, bit 1 blue LED
    typedef logic [1:0] status_t;

    // red LED lit out of reset
    localparam status_t STATUS_RESET = 2'b01;

    typedef logic [15:0] pad_state_t;
    typedef logic [2:0] buttons_t;

endpackage

//--- source/periph_top.sv
////////////////////////////////////////
// peripheral fabric top level
// decoder, arbiter and the targets
////////////////////////////////////////

`timescale 1ns/1ps

module periph_top #(
    parameter bit REGISTERED_INPUTS = 1'b1,
    parameter int RAM_WORDS = 1024
) (
    input logic vdp_clk,
    input logic vdp_reset,
    input bus_pkg::bus_req_t host_req,
    input periph_pkg::buttons_t buttons,
    output bus_pkg::data_t host_read_data,
    output logic host_ready,
    output logic led_r,
    output logic led_b
);

    bus_pkg::sel_t sel;
    logic [$clog2(RAM_WORDS)-1:0] ram_index;
    logic ram_cs;
    bus_pkg::wstrb_t ram_wstrb;
    bus_pkg::data_t ram_read_data;
    logic dsp_write;
    logic status_write;
    logic pad_write;
    periph_pkg::product_t product;
    periph_pkg::status_t status;
    logic pad_bit;

    address_decoder #(
        .REGISTERED_INPUTS(REGISTERED_INPUTS)
    ) decoder (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .req(host_req),
        .sel(sel)
    );

    bus_arbiter #(
        .RAM_WORDS(RAM_WORDS)
    ) arbiter (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .req(host_req),
        .sel(sel),
        .ram_read_data(ram_read_data),
        .product(product),
        .status(status),
        .pad_bit(pad_bit),
        .ram_index(ram_index),
        .ram_cs(ram_cs),
        .ram_wstrb(ram_wstrb),
        .dsp_write(dsp_write),
        .status_write(status_write),
        .pad_write(pad_write),
        .read_data(host_read_data),
        .ready(host_ready)
    );

    cpu_ram #(
        .RAM_WORDS(RAM_WORDS)
    ) ram (
        .vdp_clk(vdp_clk),
        .index(ram_index),
        .cs(ram_cs),
        .wstrb(ram_wstrb),
        .write_data(host_req.write_data),
        .read_data(ram_read_data)
    );

    // address bit 2 picks operand B
    dsp_mult mult (
        .vdp_clk(vdp_clk),
        .write_en(dsp_write),
        .select_b(host_req.addr[2]),
        .operand_in(periph_pkg::operand_t'(host_req.write_data[15:0])),
        .product(product)
    );

    io_ports io (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .status_write(status_write),
        .pad_write(pad_write),
        .write_bits(host_req.write_data[1:0]),
        .buttons(buttons),
        .status(status),
        .pad_bit(pad_bit),
        .led_r(led_r),
        .led_b(led_b)
    );

endmodule

//--- verification/periph_asserts.sv
////////////////////////////////////////
// bus protocol assertions
// bound into the bus arbiter
////////////////////////////////////////

`timescale 1ns/1ps

module periph_asserts (
    input logic vdp_clk,
    input logic vdp_reset,
    input bus_pkg::bus_req_t req,
    input logic ready,
    input logic ram_cs,
    input logic dsp_write,
    input logic status_write,
    input logic pad_write
);

    logic [3:0] enables;
    logic [1:0] enable_count;

    assign enables = {ram_cs, dsp_write, status_write, pad_write};

    // pulses since valid last rose
    always_ff @(posedge vdp_clk) begin
        if (vdp_reset || !req.valid) begin
            enable_count <= '0;
        end else if (|enables) begin
            enable_count <= enable_count + 2'd1;
        end
    end

    ready_single_pulse: assert property (
        @(posedge vdp_clk) disable iff (vdp_reset) ready |=> !ready
    ) else $error("ready stayed high for more than one cycle");

    one_enable_per_request: assert property (
        @(posedge vdp_clk) disable iff (vdp_reset) |enables |-> enable_count == 2'd0
    ) else $error("second target enable within one request");

    ready_needs_valid: assert property (
        @(posedge vdp_clk) disable iff (vdp_reset) $rose(ready) |-> req.valid
    ) else $error("ready rose while valid was low");

endmodule

bind bus_arbiter periph_asserts arbiter_asserts (
    .vdp_clk(vdp_clk),
    .vdp_reset(vdp_reset),
    .req(req),
    .ready(ready),
    .ram_cs(ram_cs),
    .dsp_write(dsp_write),
    .status_write(status_write),
    .pad_write(pad_write)
);

//--- verification/periph_tb.sv
////////////////////////////////////////
// peripheral fabric testbench
// plays the host CPU from a table and
// checks the answers against a model
////////////////////////////////////////

`timescale 1ns/1ps

module periph_tb;

    localparam bit REGISTERED_INPUTS = 1'b1;
    localparam int RAM_WORDS = 1024;

    typedef enum logic [2:0] {
        OP_WRITE,
        OP_READ,
        OP_READ_STATUS,
        OP_READ_PAD,
        OP_LEDS
    } op_t;

    typedef struct packed {
        op_t op;
        bus_pkg::addr_t addr;
        bus_pkg::wstrb_t wstrb;
        bus_pkg::data_t data;
        periph_pkg::buttons_t buttons;
        bus_pkg::data_t expected;
    } entry_t;

    logic vdp_clk = 1'b0;
    logic vdp_reset = 1'b1;
    bus_pkg::bus_req_t host_req = '0;
    periph_pkg::buttons_t buttons = '0;
    bus_pkg::data_t host_read_data;
    logic host_ready;
    logic led_r;
    logic led_b;

    entry_t test_table[$];
    bus_pkg::data_t ram_model [RAM_WORDS];
    periph_pkg::buttons_t pad_buttons = '0;
    logic [31:0] lfsr_state = 32'h70b4;
    logic table_built = 1'b0;
    int check_count = 0;
    int error_count = 0;

    periph_top #(
        .REGISTERED_INPUTS(REGISTERED_INPUTS),
        .RAM_WORDS(RAM_WORDS)
    ) UUT (
        .vdp_clk(vdp_clk),
        .vdp_reset(vdp_reset),
        .host_req(host_req),
        .buttons(buttons),
        .host_read_data(host_read_data),
        .host_ready(host_ready),
        .led_r(led_r),
        .led_b(led_b)
    );

    always #4 vdp_clk = ~vdp_clk;

    // galois form, one step per bit taken
    function automatic logic [31:0] random_bits(input int width);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < width; i++) begin
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic bus_pkg::data_t merge_bytes(input bus_pkg::data_t old_word,
                                                   input bus_pkg::data_t new_word,
                                                   input bus_pkg::wstrb_t strb);
        bus_pkg::data_t merged;
        merged = old_word;
        for (int b = 0; b < bus_pkg::STRB_W; b++) begin
            if (strb[b]) begin
                merged[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    // button 1 to bit 7, button 3 to bit 6, button 2 to bit 0
    function automatic periph_pkg::pad_state_t pad_pattern(input periph_pkg::buttons_t b);
        periph_pkg::pad_state_t p;
        p = '0;
        p[7] = b[0];
        p[6] = b[2];
        p[0] = b[1];
        return p;
    endfunction

    function automatic string op_name(input op_t op);
        case (op)
            OP_WRITE: return "write";
            OP_READ: return "read";
            OP_READ_STATUS: return "status read";
            OP_READ_PAD: return "pad read";
            default: return "led check";
        endcase
    endfunction

    task automatic add_entry(input op_t op, input bus_pkg::addr_t addr,
                             input bus_pkg::wstrb_t wstrb, input bus_pkg::data_t data,
                             input bus_pkg::data_t expected);
        entry_t e;
        e.op = op;
        e.addr = addr;
        e.wstrb = wstrb;
        e.data = data;
        e.buttons = pad_buttons;
        e.expected = expected;
        test_table.push_back(e);
    endtask

    task automatic add_pad_sequence(input periph_pkg::buttons_t b, input int nbits);
        periph_pkg::pad_state_t pattern;
        bus_pkg::addr_t pad_addr;
        pad_buttons = b;
        pattern = pad_pattern(b);
        pad_addr = {bus_pkg::REGION_PAD, 20'h00000};
        // latch high then low
        add_entry(OP_WRITE, pad_addr, 4'b0001, 32'h1, 32'h0);
        add_entry(OP_WRITE, pad_addr, 4'b0001, 32'h0, 32'h0);
        for (int n = 0; n < nbits; n++) begin
            if (n > 0) begin
                add_entry(OP_WRITE, pad_addr, 4'b0001, 32'h2, 32'h0);
                add_entry(OP_WRITE, pad_addr, 4'b0001, 32'h0, 32'h0);
            end
            add_entry(OP_READ_PAD, pad_addr, 4'b0000, 32'h0, {31'b0, pattern[n]});
        end
    endtask

    task automatic build_table();
        bus_pkg::data_t word;
        bus_pkg::data_t status_model;
        bus_pkg::addr_t dsp_a;
        bus_pkg::addr_t dsp_b;
        bus_pkg::addr_t status_addr;
        periph_pkg::operand_t a;
        periph_pkg::operand_t b;
        periph_pkg::product_t pa;
        periph_pkg::product_t pb;
        logic [31:0] r;
        int idx;
        dsp_a = {bus_pkg::REGION_DSP, 20'h00000};
        dsp_b = {bus_pkg::REGION_DSP, 20'h00004};
        status_addr = {bus_pkg::REGION_STATUS, 20'h00000};

        // reset state, red LED only
        status_model = 32'h1;
        add_entry(OP_LEDS, '0, '0, '0, status_model);
        add_entry(OP_READ_STATUS, status_addr, '0, '0, status_model);

        // full words first, last index tests the top address bits
        for (int k = 0; k < 5; k++) begin
            idx = (k == 4) ? RAM_WORDS - 1 : k;
            word = random_bits(32);
            ram_model[idx] = word;
            add_entry(OP_WRITE, bus_pkg::addr_t'(idx << 2), 4'hf, word, '0);
        end
        for (int k = 0; k < 4; k++) begin
            idx = (k == 3) ? RAM_WORDS - 1 : k + 1;
            word = random_bits(32);
            r = {28'h0, 4'b0011 << k};
            ram_model[idx] = merge_bytes(ram_model[idx], word, r[3:0] | 4'b0001 << (3 - k));
            add_entry(OP_WRITE, bus_pkg::addr_t'(idx << 2),
                      r[3:0] | 4'b0001 << (3 - k), word, '0);
        end
        for (int k = 0; k < 5; k++) begin
            idx = (k == 4) ? RAM_WORDS - 1 : k;
            add_entry(OP_READ, bus_pkg::addr_t'(idx << 2), '0, '0, ram_model[idx]);
        end

        // one fixed negative pair, then random operands
        for (int k = 0; k < 4; k++) begin
            if (k == 0) begin
                a = -16'sd3;
                b = 16'sd7;
            end else begin
                r = random_bits(16);
                a = r[15:0];
                r = random_bits(16);
                b = r[15:0];
            end
            pa = periph_pkg::product_t'(a);
            pb = periph_pkg::product_t'(b);
            r = random_bits(16);
            add_entry(OP_WRITE, dsp_a, 4'b0011, {r[15:0], a}, '0);
            add_entry(OP_WRITE, dsp_b, 4'b0011, {r[15:0], b}, '0);
            add_entry(OP_READ, dsp_a, '0, '0, bus_pkg::data_t'(pa * pb));
        end

        // only data bits 1:0 reach the LEDs
        status_model = 32'h2;
        add_entry(OP_WRITE, status_addr, 4'hf, 32'hffff_fff2, '0);
        add_entry(OP_LEDS, '0, '0, '0, status_model);
        add_entry(OP_READ_STATUS, status_addr, '0, '0, status_model);
        status_model = 32'h3;
        add_entry(OP_WRITE, status_addr, 4'b0001, 32'h0000_0003, '0);
        add_entry(OP_LEDS, '0, '0, '0, status_model);
        add_entry(OP_READ_STATUS, status_addr, '0, '0, status_model);

        add_pad_sequence(3'b101, 8);
        add_pad_sequence(3'b010, 2);

        // unmapped regions, one aliasing RAM word 1
        add_entry(OP_WRITE, {4'h4, 20'h00004}, 4'hf, random_bits(32), '0);
        add_entry(OP_WRITE, {4'hf, 20'h00000}, 4'hf, 32'h0, '0);
        add_entry(OP_READ, {4'h4, 20'h00004}, '0, '0, 32'h0);
        add_entry(OP_READ, 24'h000004, '0, '0, ram_model[1]);
        add_entry(OP_READ_STATUS, status_addr, '0, '0, status_model);
        add_entry(OP_LEDS, '0, '0, '0, status_model);
    endtask

    // starts and ends 1 ns after a rising edge
    task automatic bus_transfer(input entry_t e, output bus_pkg::data_t rdata);
        host_req.addr = e.addr;
        host_req.wstrb = e.wstrb;
        host_req.write_data = e.data;
        host_req.valid = 1'b1;
        @(negedge vdp_clk);
        while (host_ready !== 1'b1) begin
            @(negedge vdp_clk);
        end
        rdata = host_read_data;
        @(posedge vdp_clk);
        #1;
        host_req.valid = 1'b0;
        @(posedge vdp_clk);
        #1;
    endtask

    task automatic check_data(input string name, input bus_pkg::data_t got,
                              input bus_pkg::data_t expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("Fail %s expected %h got %h", name, expected, got);
        end
    endtask

    task automatic check_status(input string name, input periph_pkg::status_t got,
                                input periph_pkg::status_t expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("Fail %s expected %h got %h", name, expected, got);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("Fail %s expected %h got %h", name, expected, got);
        end
    endtask

    initial begin
        wait (table_built);
        repeat (test_table.size() * 20) @(posedge vdp_clk);
        $display("Timeout: the tests did not finish within %0d cycles",
                 test_table.size() * 20);
        $display("Checks failed");
        $finish;
    end

    initial begin
        entry_t e;
        bus_pkg::data_t rdata;
        int errors_before;
        build_table();
        table_built = 1'b1;
        repeat (5) @(posedge vdp_clk);
        #1;
        vdp_reset = 1'b0;

        for (int i = 0; i < test_table.size(); i++) begin
            e = test_table[i];
            errors_before = error_count;
            buttons = e.buttons;
            case (e.op)
                OP_LEDS: begin
                    @(negedge vdp_clk);
                    check_bit("led_r", led_r, e.expected[0]);
                    check_bit("led_b", led_b, e.expected[1]);
                    @(posedge vdp_clk);
                    #1;
                end
                OP_WRITE: begin
                    bus_transfer(e, rdata);
                end
                OP_READ: begin
                    bus_transfer(e, rdata);
                    check_data("host_read_data", rdata, e.expected);
                end
                OP_READ_STATUS: begin
                    bus_transfer(e, rdata);
                    check_status("status", rdata[1:0], e.expected[1:0]);
                    check_data("host_read_data", rdata, e.expected);
                end
                default: begin
                    bus_transfer(e, rdata);
                    check_bit("pad_bit", rdata[0], e.expected[0]);
                    check_data("host_read_data", rdata, e.expected);
                end
            endcase
            $display("test %0d %s addr 0x%06h %s", i, op_name(e.op), e.addr,
                     (error_count == errors_before) ? "ok" : "wrong");
        end

        $display("%0d tests, %0d checks, %0d errors", test_table.size(),
                 check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
